/* Makefile */
TOP = tb_diad

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f build.f --top-module $(TOP) -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir

/* build.f */
diad_pkg.sv
diad_axi_wr.sv
diad_fetch.sv
diad_exec.sv
diad_regfile.sv
diad_axi_rd.sv
diad_top.sv
tb_diad.sv

/* diad_axi_rd.sv */
`timescale 1ns/10ps

module diad_axi_rd (
    input  logic                          iw_clk,
    input  logic                          iw_rst,
    input  logic                          start,
    input  logic                          retire_pulse,
    input  logic                          mispred_pulse,
    input  logic                          halted,
    input  logic                          running,
    input  logic [diad_pkg::DATA_W-1:0]   host_data,
    output logic [diad_pkg::REG_AW-1:0]   host_addr,
    input  logic [diad_pkg::AXI_AW-1:0]   axi_araddr,
    input  logic                          axi_arvalid,
    output logic                          axi_arready,
    output logic [31:0]                   axi_rdata,
    output logic [1:0]                    axi_rresp,
    output logic                          axi_rvalid,
    input  logic                          axi_rready
);
    logic [31:0]                 retired_cnt;
    logic [31:0]                 mispred_cnt;
    logic [diad_pkg::AXI_AW-1:0] reg_off;
    logic                        is_reg;
    logic [31:0]                 rd_word;
    logic [1:0]                  rd_resp;

    assign axi_arready = !axi_rvalid;

    assign reg_off   = axi_araddr - diad_pkg::ADDR_REG_BASE;
    assign is_reg    = (reg_off[diad_pkg::AXI_AW-1:diad_pkg::REG_AW+2] == '0) &&
                       (reg_off[1:0] == 2'b00);
    assign host_addr = reg_off[diad_pkg::REG_AW+1:2];

    always_comb begin
        rd_word = '0;
        rd_resp = diad_pkg::RESP_OKAY;
        if (is_reg) begin
            rd_word = 32'(host_data);
        end
        else begin
            case (axi_araddr)
                diad_pkg::ADDR_STATUS:  rd_word = 32'({running, halted});
                diad_pkg::ADDR_RETIRED: rd_word = retired_cnt;
                diad_pkg::ADDR_MISPRED: rd_word = mispred_cnt;
                default:                rd_resp = diad_pkg::RESP_SLVERR; // imem is write only.
            endcase
        end
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            axi_rvalid  <= 1'b0;
            retired_cnt <= '0;
            mispred_cnt <= '0;
        end
        else begin
            if (axi_arvalid && axi_arready) begin
                axi_rvalid <= 1'b1;
            end
            else if (axi_rready) begin
                axi_rvalid <= 1'b0;
            end
            if (start) begin
                retired_cnt <= '0;
                mispred_cnt <= '0;
            end
            else begin
                retired_cnt <= retired_cnt + 32'(retire_pulse);
                mispred_cnt <= mispred_cnt + 32'(mispred_pulse);
            end
        end
    end

    // held until the host takes it.
    always_ff @(posedge iw_clk) begin
        if (axi_arvalid && axi_arready) begin
            axi_rdata <= rd_word;
            axi_rresp <= rd_resp;
        end
    end

endmodule

/* diad_axi_wr.sv */
`timescale 1ns/10ps

module diad_axi_wr (
    input  logic                          iw_clk,
    input  logic                          iw_rst,
    input  logic [diad_pkg::AXI_AW-1:0]   axi_awaddr,
    input  logic                          axi_awvalid,
    output logic                          axi_awready,
    input  logic [31:0]                   axi_wdata,
    input  logic                          axi_wvalid,
    output logic                          axi_wready,
    output logic [1:0]                    axi_bresp,
    output logic                          axi_bvalid,
    input  logic                          axi_bready,
    output logic                          imem_we,
    output logic [diad_pkg::PC_W-1:0]     imem_addr,
    output logic [diad_pkg::DATA_W-1:0]   imem_wdata,
    output logic                          start
);
    logic take;
    logic hit_imem;
    logic hit_ctrl;

    assign axi_wready = axi_awready; // both channels taken together.
    assign take       = axi_awready && axi_awvalid && axi_wvalid;

    assign hit_imem = (axi_awaddr <= diad_pkg::ADDR_IMEM_LAST) && (axi_awaddr[1:0] == 2'b00);
    assign hit_ctrl = axi_awaddr == diad_pkg::ADDR_CTRL;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            axi_awready <= 1'b0;
            axi_bvalid  <= 1'b0;
            imem_we     <= 1'b0;
            start       <= 1'b0;
        end
        else begin
            // one-cycle ready, never while a response is pending.
            axi_awready <= axi_awvalid && axi_wvalid && !axi_bvalid && !axi_awready;
            imem_we     <= take && hit_imem;
            start       <= take && hit_ctrl && axi_wdata[0];
            if (take) begin
                axi_bvalid <= 1'b1;
            end
            else if (axi_bready) begin
                axi_bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge iw_clk) begin
        if (take) begin
            imem_addr  <= axi_awaddr[diad_pkg::PC_W+1:2]; // word index.
            imem_wdata <= axi_wdata[diad_pkg::DATA_W-1:0];
            axi_bresp  <= (hit_imem || hit_ctrl) ? diad_pkg::RESP_OKAY : diad_pkg::RESP_SLVERR;
        end
    end

endmodule

/* diad_exec.sv */
`timescale 1ns/10ps

module diad_exec (
    input  logic                          iw_clk,
    input  logic                          iw_rst,
    input  logic                          start,
    input  logic                          f_valid,
    input  logic [diad_pkg::PC_W-1:0]     f_pc,
    input  diad_pkg::instr_u              f_instr,
    input  logic                          f_pred_taken,
    input  logic [diad_pkg::DATA_W-1:0]   rs_data1,
    input  logic [diad_pkg::DATA_W-1:0]   rs_data2,
    output logic [diad_pkg::REG_AW-1:0]   rs_addr1,
    output logic [diad_pkg::REG_AW-1:0]   rs_addr2,
    output logic                          wb_we,
    output logic [diad_pkg::REG_AW-1:0]   wb_addr,
    output logic [diad_pkg::DATA_W-1:0]   wb_data,
    output logic                          flush,
    output logic [diad_pkg::PC_W-1:0]     correct_pc,
    output logic                          bp_update,
    output logic [diad_pkg::PC_W-1:0]     bp_update_pc,
    output logic                          bp_update_taken,
    output logic                          retire_pulse,
    output logic                          mispred_pulse,
    output logic                          halted,
    output logic                          running
);
    logic [3:0]                  op;
    logic                        is_r;
    logic                        is_addi;
    logic                        is_br;
    logic                        is_halt;
    logic                        ex_valid;
    logic [diad_pkg::REG_AW-1:0] rd;
    logic [diad_pkg::DATA_W-1:0] opa;
    logic [diad_pkg::DATA_W-1:0] opb;
    logic [diad_pkg::DATA_W-1:0] imm_ext;
    logic [diad_pkg::DATA_W-1:0] alu;
    logic                        taken;

    assign op      = f_instr.r.opcode;
    assign is_r    = op <= diad_pkg::OP_XOR;
    assign is_addi = op == diad_pkg::OP_ADDI;
    assign is_br   = (op == diad_pkg::OP_BEQ) || (op == diad_pkg::OP_BNE);
    assign is_halt = op == diad_pkg::OP_HALT;

    // the word behind a HALT arrives once halted is set.
    assign ex_valid = f_valid && !halted && !start;

    // branches compare rd against rs1.
    assign rs_addr1 = f_instr.r.rs1;
    assign rs_addr2 = is_br ? f_instr.i.rd : f_instr.r.rs2;
    assign rd       = f_instr.r.rd;

    assign opa = (wb_we && wb_addr == rs_addr1) ? wb_data : rs_data1;
    assign opb = (wb_we && wb_addr == rs_addr2) ? wb_data : rs_data2;

    assign imm_ext = {{(diad_pkg::DATA_W-diad_pkg::IMM_W){f_instr.i.imm[diad_pkg::IMM_W-1]}},
                      f_instr.i.imm};

    always_comb begin
        alu = opa + imm_ext; // addi.
        case (op)
            diad_pkg::OP_ADD: alu = opa + opb;
            diad_pkg::OP_SUB: alu = opa - opb;
            diad_pkg::OP_AND: alu = opa & opb;
            diad_pkg::OP_OR:  alu = opa | opb;
            diad_pkg::OP_XOR: alu = opa ^ opb;
            default: ;
        endcase
    end

    assign taken = (op == diad_pkg::OP_BEQ) == (opa == opb);

    assign bp_update       = ex_valid && is_br;
    assign bp_update_pc    = f_pc;
    assign bp_update_taken = taken;

    assign flush         = bp_update && (taken != f_pred_taken);
    assign mispred_pulse = flush;
    assign correct_pc    = taken ? f_pc + f_instr.i.imm : f_pc + 1'b1;
    assign retire_pulse  = ex_valid;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            wb_we   <= 1'b0;
            halted  <= 1'b0;
            running <= 1'b0;
        end
        else if (start) begin
            wb_we   <= 1'b0;
            halted  <= 1'b0;
            running <= 1'b1;
        end
        else begin
            wb_we <= ex_valid && (is_r || is_addi) && (rd != '0);
            if (ex_valid && is_halt) begin
                halted  <= 1'b1;
                running <= 1'b0;
            end
        end
    end

    always_ff @(posedge iw_clk) begin
        wb_addr <= rd;
        wb_data <= alu;
    end

endmodule

/* diad_fetch.sv */
`timescale 1ns/10ps

module diad_fetch (
    input  logic                          iw_clk,
    input  logic                          iw_rst,
    input  logic                          imem_we,
    input  logic [diad_pkg::PC_W-1:0]     imem_addr,
    input  logic [diad_pkg::DATA_W-1:0]   imem_wdata,
    input  logic                          start,
    input  logic                          flush,
    input  logic [diad_pkg::PC_W-1:0]     correct_pc,
    input  logic                          bp_update,
    input  logic [diad_pkg::PC_W-1:0]     bp_update_pc,
    input  logic                          bp_update_taken,
    input  logic                          halted,
    output logic                          f_valid,
    output logic [diad_pkg::PC_W-1:0]     f_pc,
    output diad_pkg::instr_u              f_instr,
    output logic                          f_pred_taken
);
    logic [diad_pkg::DATA_W-1:0] imem [diad_pkg::IMEM_DEPTH];
    logic [1:0]                  bp_ctr [2**diad_pkg::BP_IDX_W];

    logic [diad_pkg::PC_W-1:0]     pc;
    logic                          active;
    diad_pkg::instr_u              fetch_word;
    logic                          is_br;
    logic                          pred_taken;
    logic [diad_pkg::PC_W-1:0]     next_pc;
    logic [diad_pkg::BP_IDX_W-1:0] upd_idx;
    logic [1:0]                    upd_ctr;

    always_ff @(posedge iw_clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    assign fetch_word = imem[pc];
    assign is_br      = (fetch_word.i.opcode == diad_pkg::OP_BEQ) ||
                        (fetch_word.i.opcode == diad_pkg::OP_BNE);
    assign pred_taken = is_br && bp_ctr[pc[diad_pkg::BP_IDX_W-1:0]][1];

    // target wraps modulo 64 with the pc width.
    assign next_pc = pred_taken ? pc + fetch_word.i.imm : pc + 1'b1;

    assign upd_idx = bp_update_pc[diad_pkg::BP_IDX_W-1:0];
    assign upd_ctr = bp_ctr[upd_idx];

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            pc      <= '0;
            active  <= 1'b0;
            f_valid <= 1'b0;
            for (int i = 0; i < 2**diad_pkg::BP_IDX_W; i++) begin
                bp_ctr[i] <= 2'b01;
            end
        end
        else if (start) begin
            pc      <= '0;
            active  <= 1'b1;
            f_valid <= 1'b0;
            for (int i = 0; i < 2**diad_pkg::BP_IDX_W; i++) begin
                bp_ctr[i] <= 2'b01; // weakly not taken.
            end
        end
        else begin
            if (bp_update) begin
                if (bp_update_taken && upd_ctr != 2'd3) begin
                    bp_ctr[upd_idx] <= upd_ctr + 2'd1;
                end
                else if (!bp_update_taken && upd_ctr != 2'd0) begin
                    bp_ctr[upd_idx] <= upd_ctr - 2'd1;
                end
            end
            if (flush) begin
                pc      <= correct_pc;
                f_valid <= 1'b0; // squash the wrong-path word.
            end
            else if (active && !halted) begin
                pc      <= next_pc;
                f_valid <= 1'b1;
            end
            else begin
                f_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge iw_clk) begin
        f_pc         <= pc;
        f_instr      <= fetch_word;
        f_pred_taken <= pred_taken;
    end

endmodule

/* diad_pkg.sv */
package diad_pkg;

    localparam int DATA_W     = 16;
    localparam int PC_W       = 6;
    localparam int IMEM_DEPTH = 64;
    localparam int REG_AW     = 3;
    localparam int BP_IDX_W   = 4;
    localparam int AXI_AW     = 9;
    localparam int IMM_W      = 6;

    // opcodes 8 to 14 execute as no-ops.
    localparam logic [3:0] OP_ADD  = 4'd0;
    localparam logic [3:0] OP_SUB  = 4'd1;
    localparam logic [3:0] OP_AND  = 4'd2;
    localparam logic [3:0] OP_OR   = 4'd3;
    localparam logic [3:0] OP_XOR  = 4'd4;
    localparam logic [3:0] OP_ADDI = 4'd5;
    localparam logic [3:0] OP_BEQ  = 4'd6;
    localparam logic [3:0] OP_BNE  = 4'd7;
    localparam logic [3:0] OP_HALT = 4'd15;

    localparam logic [AXI_AW-1:0] ADDR_IMEM_LAST = 9'h0fc;
    localparam logic [AXI_AW-1:0] ADDR_CTRL      = 9'h100;
    localparam logic [AXI_AW-1:0] ADDR_STATUS    = 9'h100;
    localparam logic [AXI_AW-1:0] ADDR_RETIRED   = 9'h104;
    localparam logic [AXI_AW-1:0] ADDR_MISPRED   = 9'h108;
    localparam logic [AXI_AW-1:0] ADDR_REG_BASE  = 9'h140;

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    typedef struct packed {
        logic [3:0]        opcode;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [2:0]        unused;
    } instr_r_t;

    typedef struct packed {
        logic [3:0]              opcode;
        logic [REG_AW-1:0]       rd;
        logic [REG_AW-1:0]       rs1;
        logic signed [IMM_W-1:0] imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

endpackage

/* diad_regfile.sv */
`timescale 1ns/10ps

module diad_regfile (
    input  logic                          iw_clk,
    input  logic                          iw_rst,
    input  logic                          start,
    input  logic [diad_pkg::REG_AW-1:0]   rs_addr1,
    input  logic [diad_pkg::REG_AW-1:0]   rs_addr2,
    input  logic                          wb_we,
    input  logic [diad_pkg::REG_AW-1:0]   wb_addr,
    input  logic [diad_pkg::DATA_W-1:0]   wb_data,
    input  logic [diad_pkg::REG_AW-1:0]   host_addr,
    output logic [diad_pkg::DATA_W-1:0]   rs_data1,
    output logic [diad_pkg::DATA_W-1:0]   rs_data2,
    output logic [diad_pkg::DATA_W-1:0]   host_data
);
    logic [diad_pkg::DATA_W-1:0] regs [2**diad_pkg::REG_AW];

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            for (int i = 0; i < 2**diad_pkg::REG_AW; i++) begin
                regs[i] <= '0;
            end
        end
        else if (start) begin
            for (int i = 0; i < 2**diad_pkg::REG_AW; i++) begin
                regs[i] <= '0;
            end
        end
        else if (wb_we && wb_addr != '0) begin
            regs[wb_addr] <= wb_data; // r0 is never written so reads zero.
        end
    end

    assign rs_data1  = regs[rs_addr1];
    assign rs_data2  = regs[rs_addr2];
    assign host_data = regs[host_addr];

endmodule

/* diad_top.sv */
`timescale 1ns/10ps

module diad_top (
    input  logic                          iw_clk,
    input  logic                          iw_rst,
    input  logic [diad_pkg::AXI_AW-1:0]   axi_awaddr,
    input  logic                          axi_awvalid,
    output logic                          axi_awready,
    input  logic [31:0]                   axi_wdata,
    input  logic                          axi_wvalid,
    output logic                          axi_wready,
    output logic [1:0]                    axi_bresp,
    output logic                          axi_bvalid,
    input  logic                          axi_bready,
    input  logic [diad_pkg::AXI_AW-1:0]   axi_araddr,
    input  logic                          axi_arvalid,
    output logic                          axi_arready,
    output logic [31:0]                   axi_rdata,
    output logic [1:0]                    axi_rresp,
    output logic                          axi_rvalid,
    input  logic                          axi_rready
);
    logic                        imem_we;
    logic [diad_pkg::PC_W-1:0]   imem_addr;
    logic [diad_pkg::DATA_W-1:0] imem_wdata;
    logic                        start;

    logic                        f_valid;
    logic [diad_pkg::PC_W-1:0]   f_pc;
    diad_pkg::instr_u            f_instr;
    logic                        f_pred_taken;

    logic                        flush;
    logic [diad_pkg::PC_W-1:0]   correct_pc;
    logic                        bp_update;
    logic [diad_pkg::PC_W-1:0]   bp_update_pc;
    logic                        bp_update_taken;
    logic                        halted;
    logic                        running;
    logic                        retire_pulse;
    logic                        mispred_pulse;

    logic [diad_pkg::REG_AW-1:0] rs_addr1;
    logic [diad_pkg::REG_AW-1:0] rs_addr2;
    logic [diad_pkg::DATA_W-1:0] rs_data1;
    logic [diad_pkg::DATA_W-1:0] rs_data2;
    logic                        wb_we;
    logic [diad_pkg::REG_AW-1:0] wb_addr;
    logic [diad_pkg::DATA_W-1:0] wb_data;
    logic [diad_pkg::REG_AW-1:0] host_addr;
    logic [diad_pkg::DATA_W-1:0] host_data;

    // every block port matches its wire by name.
    diad_axi_wr  u_axi_wr  (.*);
    diad_fetch   u_fetch   (.*);
    diad_exec    u_exec    (.*);
    diad_regfile u_regfile (.*);
    diad_axi_rd  u_axi_rd  (.*);

endmodule

/* tb_diad.sv */
`timescale 1ns/10ps

module tb_diad;

    localparam int CLK_PERIOD = 40;
    localparam int RAND_PROGS = 10;
    localparam int RAND_LEN   = 40;
    localparam int LOOP_LEN   = 13;
    localparam int POLL_LIMIT = 200;
    localparam int MODEL_MAX  = 4000;
    // instruction words loaded over the whole run, fill pattern included.
    localparam int PROG_WORDS = diad_pkg::IMEM_DEPTH + RAND_PROGS * (RAND_LEN + 1) + LOOP_LEN;
    localparam int AXI_CYCLES = 12 * (PROG_WORDS + 20 * (RAND_PROGS + 4));
    localparam int WATCHDOG_CYCLES = 200 * PROG_WORDS + AXI_CYCLES;

    logic                        iw_clk;
    logic                        iw_rst;
    logic [diad_pkg::AXI_AW-1:0] axi_awaddr;
    logic                        axi_awvalid;
    logic                        axi_awready;
    logic [31:0]                 axi_wdata;
    logic                        axi_wvalid;
    logic                        axi_wready;
    logic [1:0]                  axi_bresp;
    logic                        axi_bvalid;
    logic                        axi_bready;
    logic [diad_pkg::AXI_AW-1:0] axi_araddr;
    logic                        axi_arvalid;
    logic                        axi_arready;
    logic [31:0]                 axi_rdata;
    logic [1:0]                  axi_rresp;
    logic                        axi_rvalid;
    logic                        axi_rready;

    logic [31:0] rng;
    logic [15:0] prog [diad_pkg::IMEM_DEPTH];
    logic [15:0] exp_regs [8];
    logic [31:0] exp_retired;
    logic [31:0] exp_mispred;

    diad_top i_diad_top (.*);

    always #(CLK_PERIOD / 2) iw_clk = ~iw_clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
            stop_run("a checked value was wrong");
        end
    endtask

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [15:0] enc_r(input logic [3:0] op, input int rd, input int rs1,
                                          input int rs2);
        return {op, rd[2:0], rs1[2:0], rs2[2:0], 3'b000};
    endfunction

    function automatic logic [15:0] enc_i(input logic [3:0] op, input int rd, input int rs1,
                                          input int imm);
        return {op, rd[2:0], rs1[2:0], imm[5:0]};
    endfunction

    // ISA-level run of prog, with the 2-bit counters in program order.
    function automatic bit run_model();
        logic [15:0] w;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] res;
        logic [5:0]  pc;
        logic [5:0]  npc;
        logic [1:0]  ctr [16];
        logic        wr;
        logic        taken;
        bit          done;
        int          steps;
        pc = '0;
        done = 0;
        steps = 0;
        exp_retired = '0;
        exp_mispred = '0;
        for (int r = 0; r < 8; r++) begin
            exp_regs[r] = '0;
        end
        for (int k = 0; k < 16; k++) begin
            ctr[k] = 2'b01;
        end
        while (!done && steps < MODEL_MAX) begin
            w = prog[pc];
            a = exp_regs[w[8:6]];
            b = exp_regs[w[5:3]];
            npc = pc + 6'd1;
            wr = 1'b1;
            res = '0;
            steps++;
            exp_retired++;
            case (w[15:12])
                diad_pkg::OP_ADD:  res = a + b;
                diad_pkg::OP_SUB:  res = a - b;
                diad_pkg::OP_AND:  res = a & b;
                diad_pkg::OP_OR:   res = a | b;
                diad_pkg::OP_XOR:  res = a ^ b;
                diad_pkg::OP_ADDI: res = a + {{10{w[5]}}, w[5:0]};
                diad_pkg::OP_BEQ, diad_pkg::OP_BNE: begin
                    wr = 1'b0;
                    taken = (w[15:12] == diad_pkg::OP_BEQ) == (exp_regs[w[11:9]] == a);
                    if (taken != ctr[pc[3:0]][1]) begin
                        exp_mispred++;
                    end
                    if (taken && ctr[pc[3:0]] != 2'd3) begin
                        ctr[pc[3:0]]++;
                    end
                    else if (!taken && ctr[pc[3:0]] != 2'd0) begin
                        ctr[pc[3:0]]--;
                    end
                    if (taken) begin
                        npc = pc + w[5:0]; // wraps at 64.
                    end
                end
                diad_pkg::OP_HALT: begin
                    wr = 1'b0;
                    done = 1;
                end
                default: wr = 1'b0;
            endcase
            if (wr && w[11:9] != 3'd0) begin
                exp_regs[w[11:9]] = res;
            end
            pc = npc;
        end
        return done;
    endfunction

    task automatic axi_write(input logic [8:0] addr, input logic [31:0] data,
                             input logic [1:0] resp);
        int waits;
        int n;
        waits = int'(next_random() % 4);
        n = 0;
        axi_awaddr  = addr;
        axi_wdata   = data;
        axi_awvalid = 1'b1;
        axi_wvalid  = 1'b1;
        @(negedge iw_clk);
        while (!axi_awready) begin
            n++;
            if (n > 20) begin
                stop_run("write handshake never completed");
            end
            @(negedge iw_clk);
        end
        check("wready", axi_wready, 1);
        @(negedge iw_clk); // taken on the edge just passed.
        axi_awvalid = 1'b0;
        axi_wvalid  = 1'b0;
        for (int k = 0; k < waits; k++) begin
            check("bvalid", axi_bvalid, 1);
            @(negedge iw_clk);
        end
        check("bvalid", axi_bvalid, 1);
        check("bresp", axi_bresp, resp);
        axi_bready = 1'b1;
        @(negedge iw_clk);
        axi_bready = 1'b0;
        check("bvalid", axi_bvalid, 0);
    endtask

    task automatic axi_read(input logic [8:0] addr, input logic [1:0] resp,
                            output logic [31:0] data);
        int          waits;
        int          n;
        logic [31:0] first;
        waits = int'(next_random() % 4);
        n = 0;
        axi_araddr  = addr;
        axi_arvalid = 1'b1;
        while (!axi_arready) begin
            n++;
            if (n > 20) begin
                stop_run("read address was never accepted");
            end
            @(negedge iw_clk);
        end
        @(negedge iw_clk);
        axi_arvalid = 1'b0;
        check("rvalid", axi_rvalid, 1);
        check("rresp", axi_rresp, resp);
        first = axi_rdata;
        for (int k = 0; k < waits; k++) begin
            @(negedge iw_clk);
            check("rvalid", axi_rvalid, 1);
            check("rdata", axi_rdata, first); // must hold while waiting.
            check("rresp", axi_rresp, resp);
        end
        axi_rready = 1'b1;
        @(negedge iw_clk);
        axi_rready = 1'b0;
        check("rvalid", axi_rvalid, 0);
        data = first;
    endtask

    task automatic expect_read(input logic [8:0] addr, input logic [31:0] exp,
                               input logic [1:0] resp, input string name);
        logic [31:0] got;
        axi_read(addr, resp, got);
        check(name, got, exp);
    endtask

    task automatic load_program(input int len);
        for (int i = 0; i < len; i++) begin
            axi_write(9'(4 * i), {16'h0, prog[i]}, diad_pkg::RESP_OKAY);
        end
    endtask

    task automatic wait_halted();
        logic [31:0] st;
        int          polls;
        st = '0;
        polls = 0;
        while (!st[0]) begin
            if (polls == POLL_LIMIT) begin
                stop_run("core did not halt within the poll limit");
            end
            axi_read(diad_pkg::ADDR_STATUS, diad_pkg::RESP_OKAY, st);
            polls++;
            if (!st[0]) begin
                check("status", st, 32'h2); // still running.
            end
        end
        check("status", st, 32'h1); // halted and no longer running.
    endtask

    task automatic run_and_compare();
        axi_write(diad_pkg::ADDR_CTRL, 32'h1, diad_pkg::RESP_OKAY);
        wait_halted();
        if (!run_model()) begin
            stop_run("reference model never reached HALT");
        end
        for (int r = 0; r < 8; r++) begin
            expect_read(9'(diad_pkg::ADDR_REG_BASE + 4 * r), {16'h0, exp_regs[r]},
                        diad_pkg::RESP_OKAY, $sformatf("r%0d", r));
        end
        expect_read(diad_pkg::ADDR_RETIRED, exp_retired, diad_pkg::RESP_OKAY, "retired");
        expect_read(diad_pkg::ADDR_MISPRED, exp_mispred, diad_pkg::RESP_OKAY, "mispred");
    endtask

    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        stop_run("watchdog expired before the tests finished");
    end

    initial begin
        logic [31:0] r;
        iw_clk      = 1'b0;
        iw_rst      = 1'b1;
        axi_awaddr  = '0;
        axi_awvalid = 1'b0;
        axi_wdata   = '0;
        axi_wvalid  = 1'b0;
        axi_bready  = 1'b0;
        axi_araddr  = '0;
        axi_arvalid = 1'b0;
        axi_rready  = 1'b0;
        rng         = 32'd17;
        repeat (4) @(negedge iw_clk);
        iw_rst = 1'b0;

        // idle state before any start.
        expect_read(diad_pkg::ADDR_STATUS, '0, diad_pkg::RESP_OKAY, "status");
        expect_read(diad_pkg::ADDR_RETIRED, '0, diad_pkg::RESP_OKAY, "retired");
        expect_read(diad_pkg::ADDR_MISPRED, '0, diad_pkg::RESP_OKAY, "mispred");
        for (int i = 0; i < 8; i++) begin
            expect_read(9'(diad_pkg::ADDR_REG_BASE + 4 * i), '0, diad_pkg::RESP_OKAY,
                        $sformatf("r%0d", i));
        end

        // no-op words tagged with their own address.
        for (int i = 0; i < diad_pkg::IMEM_DEPTH; i++) begin
            axi_write(9'(4 * i), 32'h8000 | i, diad_pkg::RESP_OKAY);
        end

        for (int p = 0; p < RAND_PROGS; p++) begin
            for (int i = 0; i < RAND_LEN; i++) begin
                r = next_random();
                if (r[26:24] < 3'd5) begin
                    prog[i] = enc_r({1'b0, r[26:24]}, r[10:8], r[13:11], r[16:14]);
                end
                else begin
                    prog[i] = enc_i(diad_pkg::OP_ADDI, r[10:8], r[13:11], r[22:17]);
                end
            end
            prog[RAND_LEN] = enc_i(diad_pkg::OP_HALT, 0, 0, 0);
            load_program(RAND_LEN + 1);
            run_and_compare();
            expect_read(diad_pkg::ADDR_MISPRED, '0, diad_pkg::RESP_OKAY,
                        "straight-line mispred");
        end

        // nested BNE loops with a forward BEQ taken on the last outer pass.
        prog[0]  = enc_i(diad_pkg::OP_ADDI, 1, 0, 3);
        prog[1]  = enc_i(diad_pkg::OP_ADDI, 2, 0, 4);
        prog[2]  = enc_r(diad_pkg::OP_ADD, 3, 3, 1);
        prog[3]  = enc_i(diad_pkg::OP_ADDI, 2, 2, -1);
        prog[4]  = enc_i(diad_pkg::OP_BNE, 2, 0, -2);
        prog[5]  = enc_r(diad_pkg::OP_XOR, 4, 4, 3);
        prog[6]  = enc_i(diad_pkg::OP_BEQ, 4, 0, 2);
        prog[7]  = enc_i(diad_pkg::OP_ADDI, 5, 5, 1);
        prog[8]  = enc_i(diad_pkg::OP_ADDI, 1, 1, -1);
        prog[9]  = enc_i(diad_pkg::OP_BNE, 1, 0, -8);
        prog[10] = enc_r(diad_pkg::OP_SUB, 6, 5, 3);
        prog[11] = enc_r(diad_pkg::OP_AND, 7, 6, 3);
        prog[12] = enc_i(diad_pkg::OP_HALT, 0, 0, 0);
        load_program(LOOP_LEN);

        // unmapped and misaligned accesses.
        axi_write(9'h10c, 32'h1, diad_pkg::RESP_SLVERR);
        axi_write(9'h1fc, 32'h1, diad_pkg::RESP_SLVERR);
        axi_write(9'h002, 32'h5201, diad_pkg::RESP_SLVERR);
        expect_read(9'h10c, '0, diad_pkg::RESP_SLVERR, "unmapped read");
        expect_read(9'h000, '0, diad_pkg::RESP_SLVERR, "imem read");
        expect_read(9'h160, '0, diad_pkg::RESP_SLVERR, "past regs read");
        expect_read(9'h142, '0, diad_pkg::RESP_SLVERR, "misaligned read");

        run_and_compare();
        if (exp_mispred == 0) begin
            stop_run("loop program produced no mispredicts in the model");
        end

        // same program again, no reload.
        run_and_compare();

        $display("TEST PASS");
        $finish;
    end

endmodule
